//--- Bender.yml
package:
  name: wb_subsys

sources:
  - files:
      - verilog/wb_pkg.sv
      - verilog/wb_host_bridge.sv
      - verilog/wb_interconnect_1x2.sv
      - verilog/wb_ram_slave.sv
      - verilog/wb_fifo_slave.sv
      - verilog/wb_subsys_top.sv
  - target: simulation
    files:
      - sim/wb_subsys_tb.sv

//--- build.f
verilog/wb_pkg.sv
verilog/wb_host_bridge.sv
verilog/wb_interconnect_1x2.sv
verilog/wb_ram_slave.sv
verilog/wb_fifo_slave.sv
verilog/wb_subsys_top.sv
sim/wb_subsys_tb.sv

//--- sim/wb_subsys_tb.sv
/* Directed tests through the host command port; one command in flight at a time
   RAM and FIFO results are checked against models kept in this testbench */
`timescale 1ns/100ps
module wb_subsys_tb;
	import wb_pkg::*;

	logic    clk = 1'b0;
	logic    rstn;
	logic    cmd_stb;
	logic    cmd_we;
	wb_adr_t cmd_adr;
	wb_dat_t cmd_dat;
	wb_sel_t cmd_sel;
	logic    busy;
	logic    rsp_stb;
	wb_dat_t rsp_dat;
	logic    rsp_err;

	integer  seed = 68;
	// Expected RAM contents, indexed by word
	wb_dat_t ram_model [RAM_DEPTH];
	// Words pushed into the mailbox and not yet popped
	wb_dat_t fifo_q [$];

	wb_subsys_top i_wb_subsys_top (
		.clk(clk), .rstn(rstn),
		.cmd_stb_i(cmd_stb), .cmd_we_i(cmd_we), .cmd_adr_i(cmd_adr),
		.cmd_dat_i(cmd_dat), .cmd_sel_i(cmd_sel),
		.busy_o(busy), .rsp_stb_o(rsp_stb), .rsp_dat_o(rsp_dat), .rsp_err_o(rsp_err)
	);

	// 8 ns period
	always #4 clk = ~clk;

	task automatic abort_run();
		$display("** FAIL **");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("FAILED at %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
			abort_run();
		end
	endtask

	// One command, called 1 ns after a rising edge with busy low
	// Edge count includes the edge that samples the strobe
	task automatic bus_access(input logic we, input wb_adr_t adr, input wb_dat_t dat,
			input wb_sel_t sel, output wb_dat_t rdat, output logic err);
		int edges;
		edges   = 0;
		cmd_stb = 1'b1;
		cmd_we  = we;
		cmd_adr = adr;
		cmd_dat = dat;
		cmd_sel = sel;
		do begin
			@(posedge clk);
			#1;
			edges++;
			if (edges == 1) begin
				cmd_stb = 1'b0;
			end
			// Busy from the accepting edge until the response pulse
			check_val("busy_o", !rsp_stb, busy);
		end while (!rsp_stb && edges < 20);
		assert (rsp_stb) else begin
			$display("No response within 20 cycles for the command to address 0x%08h", adr);
			abort_run();
		end
		check_val("response latency", 32'd4, edges);
		rdat = rsp_dat;
		err  = rsp_err;
	endtask

	// Byte-lane merge into the RAM model
	task automatic model_write(input wb_adr_t adr, input wb_dat_t dat, input wb_sel_t sel);
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				ram_model[adr[9:2]][8*b +: 8] = dat[8*b +: 8];
			end
		end
	endtask

	task automatic ram_write(input wb_adr_t adr, input wb_dat_t dat, input wb_sel_t sel);
		wb_dat_t rd;
		logic    err;
		bus_access(1'b1, adr, dat, sel, rd, err);
		check_val("rsp_err_o", 1'b0, err);
		model_write(adr, dat, sel);
	endtask

	task automatic ram_read_check(input wb_adr_t adr);
		wb_dat_t rd;
		logic    err;
		bus_access(1'b0, adr, '0, 4'hF, rd, err);
		check_val("rsp_err_o", 1'b0, err);
		check_val("rsp_dat_o", ram_model[adr[9:2]], rd);
	endtask

	// Count in 3:0, empty at bit 4, full at bit 5
	function automatic wb_dat_t stat_expect(input int count);
		wb_dat_t r;
		r = '0;
		r[3:0] = count[3:0];
		r[STAT_EMPTY_BIT] = (count == 0);
		r[STAT_FULL_BIT]  = (count == FIFO_DEPTH);
		return r;
	endfunction

	task automatic fifo_push(input wb_dat_t dat, input logic exp_err);
		wb_dat_t rd;
		logic    err;
		bus_access(1'b1, FIFO_BASE + FIFO_REG_DATA, dat, 4'hF, rd, err);
		check_val("rsp_err_o", exp_err, err);
		if (!exp_err) begin
			fifo_q.push_back(dat);
		end
	endtask

	task automatic fifo_pop_check();
		wb_dat_t rd;
		logic    err;
		bus_access(1'b0, FIFO_BASE + FIFO_REG_DATA, '0, 4'hF, rd, err);
		check_val("rsp_err_o", 1'b0, err);
		check_val("rsp_dat_o", fifo_q.pop_front(), rd);
	endtask

	task automatic fifo_stat_check();
		wb_dat_t rd;
		logic    err;
		bus_access(1'b0, FIFO_BASE + FIFO_REG_STAT, '0, 4'hF, rd, err);
		check_val("rsp_err_o", 1'b0, err);
		check_val("rsp_dat_o", stat_expect(fifo_q.size()), rd);
	endtask

	task automatic reset_then_first_access();
		rstn = 1'b0;
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			#1;
			// Release after the eighth edge
			if (i == 7) begin
				rstn = 1'b1;
			end
			check_val("busy_o", 1'b0, busy);
			check_val("rsp_stb_o", 1'b0, rsp_stb);
		end
		ram_write(32'h0000_03FC, $random(seed), 4'hF);
		ram_read_check(32'h0000_03FC);
	endtask

	task automatic ram_write_readback();
		wb_adr_t adr;
		for (int i = 0; i < 16; i++) begin
			adr = ((i * 13) % 255) * 4;
			ram_write(adr, $random(seed), 4'hF);
		end
		for (int i = 0; i < 16; i++) begin
			adr = ((i * 13) % 255) * 4;
			ram_read_check(adr);
		end
	endtask

	task automatic byte_select_merge();
		ram_write(32'h0000_0200, $random(seed), 4'hF);
		ram_write(32'h0000_0200, $random(seed), 4'b0101);
		ram_read_check(32'h0000_0200);
		ram_write(32'h0000_0200, $random(seed), 4'b1000);
		ram_read_check(32'h0000_0200);
	endtask

	task automatic fifo_order_and_status();
		for (int i = 0; i < 5; i++) begin
			fifo_push($random(seed), 1'b0);
		end
		fifo_stat_check();
		while (fifo_q.size() > 0) begin
			fifo_pop_check();
		end
		fifo_stat_check();
	endtask

	task automatic fifo_empty_and_full();
		wb_dat_t rd;
		logic    err;
		// Pop from empty
		bus_access(1'b0, FIFO_BASE + FIFO_REG_DATA, '0, 4'hF, rd, err);
		check_val("rsp_err_o", 1'b1, err);
		for (int i = 0; i < FIFO_DEPTH; i++) begin
			fifo_push($random(seed), 1'b0);
		end
		fifo_stat_check();
		// Ninth push is refused and the count stays at 8
		fifo_push($random(seed), 1'b1);
		fifo_stat_check();
		while (fifo_q.size() > 0) begin
			fifo_pop_check();
		end
	endtask

	task automatic unmapped_address_errors();
		wb_dat_t rd;
		logic    err;
		bus_access(1'b0, 32'h0000_2000, '0, 4'hF, rd, err);
		check_val("rsp_err_o", 1'b1, err);
		check_val("rsp_dat_o", 32'h0, rd);
		bus_access(1'b1, 32'h0000_2000, $random(seed), 4'hF, rd, err);
		check_val("rsp_err_o", 1'b1, err);
		bus_access(1'b1, 32'hFFFF_FFF0, $random(seed), 4'hF, rd, err);
		check_val("rsp_err_o", 1'b1, err);
		bus_access(1'b0, 32'hFFFF_FFF0, '0, 4'hF, rd, err);
		check_val("rsp_err_o", 1'b1, err);
		check_val("rsp_dat_o", 32'h0, rd);
		// Bus must still serve the RAM afterwards
		ram_read_check(32'h0000_0034);
	endtask

	initial begin
		rstn    = 1'b0;
		cmd_stb = 1'b0;
		cmd_we  = 1'b0;
		cmd_adr = '0;
		cmd_dat = '0;
		cmd_sel = '0;
		reset_then_first_access();
		ram_write_readback();
		byte_select_merge();
		fifo_order_and_status();
		fifo_empty_and_full();
		unmapped_address_errors();
		$display("** PASS **");
		$finish;
	end

endmodule

//--- verilog/wb_fifo_slave.sv
/* Eight-word mailbox at two registers; SEL is ignored and every access moves a word
   Push when full, pop when empty and any other offset answer with ERR */
`timescale 1ns/100ps
module wb_fifo_slave (
	input  logic            clk,
	input  logic            rstn,
	input  logic            wb_cyc_i,
	input  logic            wb_stb_i,
	input  logic            wb_we_i,
	input  wb_pkg::wb_adr_t wb_adr_i,
	input  wb_pkg::wb_dat_t wb_dat_i,
	input  wb_pkg::wb_sel_t wb_sel_i,
	output wb_pkg::wb_dat_t wb_dat_o,
	output logic            wb_ack_o,
	output logic            wb_err_o
);
	import wb_pkg::*;

	wb_dat_t                mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0]  wr_ptr_q;
	logic [FIFO_PTR_W-1:0]  rd_ptr_q;
	logic [FIFO_CNT_W-1:0]  count_q;
	logic                   req;
	logic                   is_data;
	logic                   is_stat;
	logic                   empty;
	logic                   full;
	logic                   do_push;
	logic                   do_pop;
	logic                   stat_rd;
	wb_dat_t                stat_word;

	assign req     = wb_cyc_i && wb_stb_i && !wb_ack_o && !wb_err_o;
	// Low nibble picks the register
	assign is_data = (wb_adr_i[3:0] == FIFO_REG_DATA);
	assign is_stat = (wb_adr_i[3:0] == FIFO_REG_STAT);
	assign empty   = (count_q == '0);
	assign full    = (count_q == FIFO_CNT_W'(FIFO_DEPTH));

	// Accepted accesses
	assign do_push = req && wb_we_i && is_data && !full;
	assign do_pop  = req && !wb_we_i && is_data && !empty;
	assign stat_rd = req && !wb_we_i && is_stat;

	always_comb begin
		stat_word = '0;
		stat_word[FIFO_CNT_W-1:0] = count_q;
		stat_word[STAT_EMPTY_BIT] = empty;
		stat_word[STAT_FULL_BIT]  = full;
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
			wb_ack_o <= 1'b0;
			wb_err_o <= 1'b0;
		end else begin
			wb_ack_o <= do_push || do_pop || stat_rd;
			// Rejected access leaves pointers and count alone
			wb_err_o <= req && !(do_push || do_pop || stat_rd);
			// Pointers wrap on their own at depth 8
			if (do_push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
				count_q  <= count_q + 1'b1;
			end else if (do_pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
				count_q  <= count_q - 1'b1;
			end
		end
	end

	// Storage and read data
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr_q] <= wb_dat_i;
		end
		if (do_pop) begin
			wb_dat_o <= mem[rd_ptr_q];
		end else if (stat_rd) begin
			wb_dat_o <= stat_word;
		end else if (req) begin
			wb_dat_o <= '0;
		end
	end

	a_count_max: assert property (@(posedge clk) disable iff (!rstn)
		count_q <= FIFO_CNT_W'(FIFO_DEPTH));

endmodule

//--- verilog/wb_host_bridge.sv
/* Only one command in flight; cmd_stb_i while busy_o is high is a protocol error
   rsp_dat_o and rsp_err_o are valid only in the rsp_stb_o cycle */
`timescale 1ns/100ps
module wb_host_bridge (
	input  logic            clk,
	input  logic            rstn,
	input  logic            cmd_stb_i,
	input  logic            cmd_we_i,
	input  wb_pkg::wb_adr_t cmd_adr_i,
	input  wb_pkg::wb_dat_t cmd_dat_i,
	input  wb_pkg::wb_sel_t cmd_sel_i,
	input  wb_pkg::wb_dat_t wb_dat_i,
	input  logic            wb_ack_i,
	input  logic            wb_err_i,
	output logic            busy_o,
	output logic            rsp_stb_o,
	output wb_pkg::wb_dat_t rsp_dat_o,
	output logic            rsp_err_o,
	output logic            wb_cyc_o,
	output logic            wb_stb_o,
	output logic            wb_we_o,
	output wb_pkg::wb_adr_t wb_adr_o,
	output wb_pkg::wb_dat_t wb_dat_o,
	output wb_pkg::wb_sel_t wb_sel_o
);
	import wb_pkg::*;

	host_state_t state_q;
	logic        cmd_take;
	logic        rsp_take;

	// Command accepted only in idle
	assign cmd_take = (state_q == HOST_IDLE) && cmd_stb_i;
	// Slave answered the open cycle
	assign rsp_take = (state_q == HOST_BUS) && (wb_ack_i || wb_err_i);

	// CYC and STB stay up for the whole bus phase
	assign busy_o   = (state_q == HOST_BUS);
	assign wb_cyc_o = (state_q == HOST_BUS);
	assign wb_stb_o = (state_q == HOST_BUS);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q   <= HOST_IDLE;
			rsp_stb_o <= 1'b0;
		end else begin
			// Response strobe is a single-cycle pulse
			rsp_stb_o <= rsp_take;
			if (cmd_take) begin
				state_q <= HOST_BUS;
			end else if (rsp_take) begin
				state_q <= HOST_IDLE;
			end
		end
	end

	// Bus request payload held for the whole cycle
	always_ff @(posedge clk) begin
		if (cmd_take) begin
			wb_we_o  <= cmd_we_i;
			wb_adr_o <= cmd_adr_i;
			wb_dat_o <= cmd_dat_i;
			wb_sel_o <= cmd_sel_i;
		end
		// Read data and error flag land with the response pulse
		if (rsp_take) begin
			rsp_dat_o <= wb_dat_i;
			rsp_err_o <= wb_err_i;
		end
	end

	// Host must wait for busy_o to fall before the next strobe
	a_cmd_not_busy: assert property (@(posedge clk) disable iff (!rstn)
		cmd_stb_i |-> !busy_o);

	// Routed slave answers with ACK or ERR but never both
	a_ack_err_excl: assert property (@(posedge clk) disable iff (!rstn)
		wb_cyc_o |-> !(wb_ack_i && wb_err_i));

endmodule

//--- verilog/wb_interconnect_1x2.sv
/* One master, two slaves; unmapped addresses get a one-cycle ERR with zero data
   Route is latched one edge after the request and held until ACK or ERR */
`timescale 1ns/100ps
module wb_interconnect_1x2 (
	input  logic            clk,
	input  logic            rstn,
	// Master side
	input  logic            m_cyc_i,
	input  logic            m_stb_i,
	input  logic            m_we_i,
	input  wb_pkg::wb_adr_t m_adr_i,
	input  wb_pkg::wb_dat_t m_dat_i,
	input  wb_pkg::wb_sel_t m_sel_i,
	output wb_pkg::wb_dat_t m_dat_o,
	output logic            m_ack_o,
	output logic            m_err_o,
	// Slave 0, RAM
	output logic            s0_cyc_o,
	output logic            s0_stb_o,
	output logic            s0_we_o,
	output wb_pkg::wb_adr_t s0_adr_o,
	output wb_pkg::wb_dat_t s0_dat_o,
	output wb_pkg::wb_sel_t s0_sel_o,
	input  wb_pkg::wb_dat_t s0_dat_i,
	input  logic            s0_ack_i,
	input  logic            s0_err_i,
	// Slave 1, FIFO mailbox
	output logic            s1_cyc_o,
	output logic            s1_stb_o,
	output logic            s1_we_o,
	output wb_pkg::wb_adr_t s1_adr_o,
	output wb_pkg::wb_dat_t s1_dat_o,
	output wb_pkg::wb_sel_t s1_sel_o,
	input  wb_pkg::wb_dat_t s1_dat_i,
	input  logic            s1_ack_i,
	input  logic            s1_err_i
);
	import wb_pkg::*;

	route_state_t route_st_q;
	slave_id_t    route_q;
	logic         sel_ram;
	logic         sel_fifo;
	logic         none_stb;
	logic         none_err_q;

	// Map an address to its slave, or to the decode-fail responder
	function automatic slave_id_t decode_adr(input wb_adr_t adr);
		if (adr >= RAM_BASE && adr <= RAM_LIMIT) begin
			return SLV_RAM;
		end
		if (adr >= FIFO_BASE && adr <= FIFO_LIMIT) begin
			return SLV_FIFO;
		end
		return SLV_NONE;
	endfunction

	// Route FSM
	always_ff @(posedge clk) begin
		if (!rstn) begin
			route_st_q <= ROUTE_IDLE;
			route_q    <= SLV_IDLE;
		end else begin
			case (route_st_q)
				ROUTE_IDLE: begin
					if (m_cyc_i && m_stb_i) begin
						route_st_q <= ROUTE_ACTIVE;
						route_q    <= decode_adr(m_adr_i);
					end
				end
				ROUTE_ACTIVE: begin
					// Release once the master sees the answer, or if it drops CYC
					if (m_ack_o || m_err_o || !m_cyc_i) begin
						route_st_q <= ROUTE_IDLE;
						route_q    <= SLV_IDLE;
					end
				end
				default: begin
					route_st_q <= ROUTE_IDLE;
					route_q    <= SLV_IDLE;
				end
			endcase
		end
	end

	assign sel_ram  = (route_q == SLV_RAM);
	assign sel_fifo = (route_q == SLV_FIFO);

	// Request steering
	// Unrouted slave sees all zeros
	assign s0_cyc_o = sel_ram ? m_cyc_i : 1'b0;
	assign s0_stb_o = sel_ram ? m_stb_i : 1'b0;
	assign s0_we_o  = sel_ram ? m_we_i : 1'b0;
	assign s0_adr_o = sel_ram ? m_adr_i : '0;
	assign s0_dat_o = sel_ram ? m_dat_i : '0;
	assign s0_sel_o = sel_ram ? m_sel_i : '0;

	assign s1_cyc_o = sel_fifo ? m_cyc_i : 1'b0;
	assign s1_stb_o = sel_fifo ? m_stb_i : 1'b0;
	assign s1_we_o  = sel_fifo ? m_we_i : 1'b0;
	assign s1_adr_o = sel_fifo ? m_adr_i : '0;
	assign s1_dat_o = sel_fifo ? m_dat_i : '0;
	assign s1_sel_o = sel_fifo ? m_sel_i : '0;

	// Decode-fail responder
	// Same one-edge latency as a real slave
	assign none_stb = (route_q == SLV_NONE) && m_cyc_i && m_stb_i;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			none_err_q <= 1'b0;
		end else begin
			none_err_q <= none_stb && !none_err_q;
		end
	end

	// Response path is combinational from the routed slave
	always_comb begin
		m_dat_o = '0;
		m_ack_o = 1'b0;
		m_err_o = 1'b0;
		case (route_q)
			SLV_RAM: begin
				m_dat_o = s0_dat_i;
				m_ack_o = s0_ack_i;
				m_err_o = s0_err_i;
			end
			SLV_FIFO: begin
				m_dat_o = s1_dat_i;
				m_ack_o = s1_ack_i;
				m_err_o = s1_err_i;
			end
			SLV_NONE: m_err_o = none_err_q;
			default: m_dat_o = '0;
		endcase
	end

	// A slave answers only while it holds the route
	a_s0_resp_routed: assert property (@(posedge clk) disable iff (!rstn)
		(s0_ack_i || s0_err_i) |-> sel_ram);
	a_s1_resp_routed: assert property (@(posedge clk) disable iff (!rstn)
		(s1_ack_i || s1_err_i) |-> sel_fifo);

endmodule

//--- verilog/wb_pkg.sv
/* Fixed bus widths, address map and sizes for the one-master Wishbone subsystem
   Only classic single cycles are carried; CTI and BTE do not exist here */
package wb_pkg;

	// Bus widths
	localparam int WB_ADR_W = 32;
	localparam int WB_DAT_W = 32;
	localparam int WB_SEL_W = WB_DAT_W / 8;

	typedef logic [WB_ADR_W-1:0] wb_adr_t;
	typedef logic [WB_DAT_W-1:0] wb_dat_t;
	typedef logic [WB_SEL_W-1:0] wb_sel_t;

	// Route target of the interconnect
	typedef logic [1:0] slave_id_t;

	localparam slave_id_t SLV_RAM  = 2'd0;
	localparam slave_id_t SLV_FIFO = 2'd1;
	// Decode-fail responder inside the interconnect
	localparam slave_id_t SLV_NONE = 2'd2;
	localparam slave_id_t SLV_IDLE = 2'd3;

	// Address map with inclusive limits
	localparam wb_adr_t RAM_BASE   = 32'h0000_0000;
	localparam wb_adr_t RAM_LIMIT  = 32'h0000_03FF;
	localparam wb_adr_t FIFO_BASE  = 32'h0000_1000;
	localparam wb_adr_t FIFO_LIMIT = 32'h0000_100F;

	// RAM and FIFO sizes
	localparam int RAM_DEPTH  = 256;
	localparam int RAM_IDX_W  = $clog2(RAM_DEPTH);
	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W = FIFO_PTR_W + 1;

	// Register offsets inside the FIFO window
	localparam logic [3:0] FIFO_REG_DATA = 4'h0;
	localparam logic [3:0] FIFO_REG_STAT = 4'h4;

	// Status word flags
	// Count sits in bits 3:0
	localparam int STAT_EMPTY_BIT = 4;
	localparam int STAT_FULL_BIT  = 5;

	typedef enum logic {HOST_IDLE, HOST_BUS} host_state_t;
	typedef enum logic {ROUTE_IDLE, ROUTE_ACTIVE} route_state_t;

endpackage

//--- verilog/wb_ram_slave.sv
/* 256-word RAM; only address bits 9:2 are decoded, so the window aliases above that
   Never raises ERR; ACK and read data come one edge after STB */
`timescale 1ns/100ps
module wb_ram_slave (
	input  logic            clk,
	input  logic            rstn,
	input  logic            wb_cyc_i,
	input  logic            wb_stb_i,
	input  logic            wb_we_i,
	input  wb_pkg::wb_adr_t wb_adr_i,
	input  wb_pkg::wb_dat_t wb_dat_i,
	input  wb_pkg::wb_sel_t wb_sel_i,
	output wb_pkg::wb_dat_t wb_dat_o,
	output logic            wb_ack_o,
	output logic            wb_err_o
);
	import wb_pkg::*;

	wb_dat_t               mem [RAM_DEPTH];
	logic [RAM_IDX_W-1:0]  idx;
	logic                  req;

	// Word index from the byte address
	assign idx = wb_adr_i[RAM_IDX_W+1:2];

	// New access only while the previous one is not yet answered
	assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;

	// Every access in range succeeds
	assign wb_err_o = 1'b0;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			wb_ack_o <= 1'b0;
		end else begin
			wb_ack_o <= req;
		end
	end

	// Storage and read port
	always_ff @(posedge clk) begin
		if (req && wb_we_i) begin
			// Byte lanes written only where SEL is set
			for (int b = 0; b < WB_SEL_W; b++) begin
				if (wb_sel_i[b]) begin
					mem[idx][8*b +: 8] <= wb_dat_i[8*b +: 8];
				end
			end
		end
		// Read returns the full word regardless of SEL
		if (req && !wb_we_i) begin
			wb_dat_o <= mem[idx];
		end
	end

endmodule

//--- verilog/wb_subsys_top.sv
/* Host command port in, one Wishbone cycle per command, response after four edges
   RAM at 0x0000_0000 and FIFO mailbox at 0x0000_1000; anything else answers ERR */
`timescale 1ns/100ps
module wb_subsys_top (
	input  logic            clk,
	input  logic            rstn,
	input  logic            cmd_stb_i,
	input  logic            cmd_we_i,
	input  wb_pkg::wb_adr_t cmd_adr_i,
	input  wb_pkg::wb_dat_t cmd_dat_i,
	input  wb_pkg::wb_sel_t cmd_sel_i,
	output logic            busy_o,
	output logic            rsp_stb_o,
	output wb_pkg::wb_dat_t rsp_dat_o,
	output logic            rsp_err_o
);
	import wb_pkg::*;

	// Master bus
	logic    m_cyc, m_stb, m_we, m_ack, m_err;
	wb_adr_t m_adr;
	wb_dat_t m_dat_w, m_dat_r;
	wb_sel_t m_sel;
	// RAM slave bus
	logic    s0_cyc, s0_stb, s0_we, s0_ack, s0_err;
	wb_adr_t s0_adr;
	wb_dat_t s0_dat_w, s0_dat_r;
	wb_sel_t s0_sel;
	// FIFO slave bus
	logic    s1_cyc, s1_stb, s1_we, s1_ack, s1_err;
	wb_adr_t s1_adr;
	wb_dat_t s1_dat_w, s1_dat_r;
	wb_sel_t s1_sel;

	wb_host_bridge i_host_bridge (
		.clk(clk), .rstn(rstn),
		.cmd_stb_i(cmd_stb_i), .cmd_we_i(cmd_we_i), .cmd_adr_i(cmd_adr_i),
		.cmd_dat_i(cmd_dat_i), .cmd_sel_i(cmd_sel_i),
		.wb_dat_i(m_dat_r), .wb_ack_i(m_ack), .wb_err_i(m_err),
		.busy_o(busy_o), .rsp_stb_o(rsp_stb_o), .rsp_dat_o(rsp_dat_o), .rsp_err_o(rsp_err_o),
		.wb_cyc_o(m_cyc), .wb_stb_o(m_stb), .wb_we_o(m_we),
		.wb_adr_o(m_adr), .wb_dat_o(m_dat_w), .wb_sel_o(m_sel)
	);

	wb_interconnect_1x2 i_interconnect (
		.clk(clk), .rstn(rstn),
		.m_cyc_i(m_cyc), .m_stb_i(m_stb), .m_we_i(m_we),
		.m_adr_i(m_adr), .m_dat_i(m_dat_w), .m_sel_i(m_sel),
		.m_dat_o(m_dat_r), .m_ack_o(m_ack), .m_err_o(m_err),
		.s0_cyc_o(s0_cyc), .s0_stb_o(s0_stb), .s0_we_o(s0_we),
		.s0_adr_o(s0_adr), .s0_dat_o(s0_dat_w), .s0_sel_o(s0_sel),
		.s0_dat_i(s0_dat_r), .s0_ack_i(s0_ack), .s0_err_i(s0_err),
		.s1_cyc_o(s1_cyc), .s1_stb_o(s1_stb), .s1_we_o(s1_we),
		.s1_adr_o(s1_adr), .s1_dat_o(s1_dat_w), .s1_sel_o(s1_sel),
		.s1_dat_i(s1_dat_r), .s1_ack_i(s1_ack), .s1_err_i(s1_err)
	);

	wb_ram_slave i_ram (
		.clk(clk), .rstn(rstn),
		.wb_cyc_i(s0_cyc), .wb_stb_i(s0_stb), .wb_we_i(s0_we),
		.wb_adr_i(s0_adr), .wb_dat_i(s0_dat_w), .wb_sel_i(s0_sel),
		.wb_dat_o(s0_dat_r), .wb_ack_o(s0_ack), .wb_err_o(s0_err)
	);

	wb_fifo_slave i_fifo (
		.clk(clk), .rstn(rstn),
		.wb_cyc_i(s1_cyc), .wb_stb_i(s1_stb), .wb_we_i(s1_we),
		.wb_adr_i(s1_adr), .wb_dat_i(s1_dat_w), .wb_sel_i(s1_sel),
		.wb_dat_o(s1_dat_r), .wb_ack_o(s1_ack), .wb_err_o(s1_err)
	);

endmodule
